/* csr_access.sv */
`timescale 1ns/1ps

module csr_access
(
  input  logic                          cmd_v_i,
  input  csr_pkg::csr_op_e              op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
  input  logic [csr_pkg::XLEN-1:0]      wdata_i,
  input  csr_pkg::priv_e                priv_i,
  output logic [csr_pkg::XLEN-1:0]      data_o,
  output logic                          illegal_o,
  csr_wr_if.access                      wr
);
  import csr_pkg::*;

  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] old_val;
  logic            known;
  logic            priv_ok;

  assign wr.wr_addr = csr_addr_e'(addr_i);
  assign old_val    = wr.rd_data;
  assign data_o     = old_val;

  assign known = addr_i inside {csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mcountinhibit,
                                csr_mscratch, csr_mepc, csr_mcause, csr_mtval, csr_mip,
                                csr_mcycle, csr_minstret, csr_cycle, csr_instret,
                                csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid};

  // Bits 9:8 encode the lowest privilege allowed
  assign priv_ok   = 2'(priv_i) >= addr_i[9:8];
  assign illegal_o = cmd_v_i & (~priv_ok | ~known);
  assign wr.wr_v   = cmd_v_i & ~illegal_o & (op_i != csrr);

  assign imm = XLEN'(wdata_i[4:0]);

  always_comb
  begin
    case (op_i)
      csrrw:   wr.wr_data = wdata_i;
      csrrs:   wr.wr_data = old_val | wdata_i;
      csrrc:   wr.wr_data = old_val & ~wdata_i;
      csrrwi:  wr.wr_data = imm;
      csrrsi:  wr.wr_data = old_val | imm;
      csrrci:  wr.wr_data = old_val & ~imm;
      default: wr.wr_data = old_val;
    endcase
  end

endmodule

/* csr_if.sv */
`timescale 1ns/1ps

interface csr_wr_if;
  import csr_pkg::*;

  logic            wr_v;
  csr_addr_e       wr_addr;
  logic [XLEN-1:0] wr_data;
  logic [XLEN-1:0] rd_data;

  modport access  (output wr_v, output wr_addr, output wr_data, input rd_data);
  modport regfile (input wr_v, input wr_addr, input wr_data, output rd_data);
endinterface

interface trap_upd_if;
  import csr_pkg::*;

  logic               trap_v;
  logic               mret_v;
  logic [XLEN-1:0]    epc;
  // Interrupt flag on top of the code
  logic [ECODE_W:0]   cause;
  logic [XLEN-1:0]    tval;
  priv_e              prev_priv;

  logic               mstatus_mie;
  logic               mstatus_mpie;
  priv_e              mstatus_mpp;
  logic [XLEN-1:0]    mtvec_base;
  logic [XLEN-1:0]    mepc;
  logic [CAUSE_W-1:0] irq_en_pend;

  modport master (output trap_v, mret_v, epc, cause, tval, prev_priv,
                  input mstatus_mie, mstatus_mpie, mstatus_mpp, mtvec_base, mepc, irq_en_pend);
  modport slave  (input trap_v, mret_v, epc, cause, tval, prev_priv,
                  output mstatus_mie, mstatus_mpie, mstatus_mpp, mtvec_base, mepc, irq_en_pend);
endinterface

/* csr_pkg.sv */
package csr_pkg;

  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;
  localparam int ECODE_W    = 4;
  localparam int CAUSE_W    = 16;

  localparam logic [XLEN-1:0] BOOT_PC = 64'h0000_0000_8000_0000;

  typedef enum logic [CSR_ADDR_W-1:0] {
    csr_mstatus       = 12'h300,
    csr_misa          = 12'h301,
    csr_mie           = 12'h304,
    csr_mtvec         = 12'h305,
    csr_mcountinhibit = 12'h320,
    csr_mscratch      = 12'h340,
    csr_mepc          = 12'h341,
    csr_mcause        = 12'h342,
    csr_mtval         = 12'h343,
    csr_mip           = 12'h344,
    csr_mcycle        = 12'hb00,
    csr_minstret      = 12'hb02,
    csr_cycle         = 12'hc00,
    csr_instret       = 12'hc02,
    csr_mvendorid     = 12'hf11,
    csr_marchid       = 12'hf12,
    csr_mimpid        = 12'hf13,
    csr_mhartid       = 12'hf14
  } csr_addr_e;

  typedef enum logic [2:0] {
    csrr   = 3'd0,
    csrrw  = 3'd1,
    csrrs  = 3'd2,
    csrrc  = 3'd3,
    csrrwi = 3'd5,
    csrrsi = 3'd6,
    csrrci = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_m = 2'd3
  } priv_e;

  // One bit per RISC-V exception code
  typedef logic [CAUSE_W-1:0] exc_vec_t;

  localparam logic [ECODE_W-1:0] EXC_INSTR_MISALIGNED = 4'd0;
  localparam logic [ECODE_W-1:0] EXC_ILLEGAL_INSTR    = 4'd2;
  localparam logic [ECODE_W-1:0] EXC_BREAKPOINT       = 4'd3;
  localparam logic [ECODE_W-1:0] EXC_LOAD_MISALIGNED  = 4'd4;
  localparam logic [ECODE_W-1:0] EXC_STORE_MISALIGNED = 4'd6;
  localparam logic [ECODE_W-1:0] EXC_ECALL_U          = 4'd8;
  localparam logic [ECODE_W-1:0] EXC_ECALL_M          = 4'd11;

  localparam int IRQ_M_SOFT  = 3;
  localparam int IRQ_M_TIMER = 7;
  localparam int IRQ_M_EXT   = 11;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;

  localparam logic [XLEN-1:0] MARCHID_VAL = 64'd13;
  localparam logic [XLEN-1:0] MIMPID_VAL  = 64'd1;
  // RV64 with A, I, M and U
  localparam logic [XLEN-1:0] MISA_VAL    = 64'h8000_0000_0010_1101;

  localparam logic [XLEN-1:0] MSTATUS_WMASK = 64'h0000_0000_0000_1888;
  localparam logic [XLEN-1:0] MIP_WMASK     = 64'h0;

  // Lowest set bit wins
  function automatic logic [ECODE_W-1:0] lowest_set(input logic [CAUSE_W-1:0] vec);
    logic [ECODE_W-1:0] code;
    code = '0;
    for (int i = CAUSE_W - 1; i >= 0; i--)
    begin
      if (vec[i])
        code = ECODE_W'(i);
    end
    return code;
  endfunction

endpackage

/* csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     irq_timer_i,
  input  logic                     irq_soft_i,
  input  logic                     irq_ext_i,
  input  logic [csr_pkg::XLEN-1:0] mcycle_i,
  input  logic [csr_pkg::XLEN-1:0] minstret_i,
  output logic                     cnt_wr_cycle_o,
  output logic                     cnt_wr_instret_o,
  output logic [csr_pkg::XLEN-1:0] cnt_wdata_o,
  output logic [1:0]               inhibit_o,
  csr_wr_if.regfile                wr,
  trap_upd_if.slave                upd
);
  import csr_pkg::*;

  logic [XLEN-1:0] mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q, mip_q;
  logic [XLEN-1:0] mstatus_n, mie_n, mtvec_n, mscratch_n, mepc_n, mcause_n, mtval_n, mip_n;
  logic [1:0]      inhibit_q;
  logic [1:0]      inhibit_n;

  always_comb
  begin
    case (wr.wr_addr)
      csr_cycle, csr_mcycle:       wr.rd_data = mcycle_i;
      csr_instret, csr_minstret:   wr.rd_data = minstret_i;
      csr_marchid:                 wr.rd_data = MARCHID_VAL;
      csr_mimpid:                  wr.rd_data = MIMPID_VAL;
      csr_misa:                    wr.rd_data = MISA_VAL;
      csr_mstatus:                 wr.rd_data = mstatus_q;
      csr_mie:                     wr.rd_data = mie_q;
      csr_mtvec:                   wr.rd_data = mtvec_q;
      csr_mscratch:                wr.rd_data = mscratch_q;
      csr_mepc:                    wr.rd_data = mepc_q;
      csr_mcause:                  wr.rd_data = mcause_q;
      csr_mtval:                   wr.rd_data = mtval_q;
      csr_mip:                     wr.rd_data = mip_q;
      csr_mcountinhibit:           wr.rd_data = XLEN'({inhibit_q[1], 1'b0, inhibit_q[0]});
      // mvendorid and mhartid read as zero
      default:                     wr.rd_data = '0;
    endcase
  end

  always_comb
  begin
    mstatus_n  = mstatus_q;
    mie_n      = mie_q;
    mtvec_n    = mtvec_q;
    mscratch_n = mscratch_q;
    mepc_n     = mepc_q;
    mcause_n   = mcause_q;
    mtval_n    = mtval_q;
    inhibit_n  = inhibit_q;

    mip_n              = '0;
    mip_n[IRQ_M_SOFT]  = irq_soft_i;
    mip_n[IRQ_M_TIMER] = irq_timer_i;
    mip_n[IRQ_M_EXT]   = irq_ext_i;

    // Information registers and the user counter views drop writes
    if (wr.wr_v)
    begin
      case (wr.wr_addr)
        csr_mstatus:
        begin
          mstatus_n = (mstatus_q & ~MSTATUS_WMASK) | (wr.wr_data & MSTATUS_WMASK);
          // Only M and U exist
          if (wr.wr_data[MSTATUS_MPP +: 2] != 2'(priv_m))
            mstatus_n[MSTATUS_MPP +: 2] = 2'(priv_u);
        end
        csr_mie:           mie_n      = wr.wr_data;
        csr_mtvec:         mtvec_n    = wr.wr_data;
        csr_mscratch:      mscratch_n = wr.wr_data;
        csr_mepc:          mepc_n     = wr.wr_data;
        csr_mcause:        mcause_n   = wr.wr_data;
        csr_mtval:         mtval_n    = wr.wr_data;
        csr_mip:           mip_n      = (mip_n & ~MIP_WMASK) | (wr.wr_data & MIP_WMASK);
        csr_mcountinhibit: inhibit_n  = {wr.wr_data[2], wr.wr_data[0]};
        default:           mstatus_n  = mstatus_q;
      endcase
    end

    if (upd.trap_v)
    begin
      mstatus_n                   = mstatus_q;
      mstatus_n[MSTATUS_MPIE]     = mstatus_q[MSTATUS_MIE];
      mstatus_n[MSTATUS_MIE]      = 1'b0;
      mstatus_n[MSTATUS_MPP +: 2] = upd.prev_priv;
      mepc_n   = upd.epc;
      mcause_n = {upd.cause[ECODE_W], {(XLEN - ECODE_W - 1){1'b0}}, upd.cause[ECODE_W-1:0]};
      mtval_n  = upd.tval;
    end
    else if (upd.mret_v)
    begin
      mstatus_n                   = mstatus_q;
      mstatus_n[MSTATUS_MIE]      = mstatus_q[MSTATUS_MPIE];
      mstatus_n[MSTATUS_MPIE]     = 1'b1;
      mstatus_n[MSTATUS_MPP +: 2] = 2'(priv_u);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
      inhibit_q  <= '0;
    end
    else
    begin
      mstatus_q  <= mstatus_n;
      mie_q      <= mie_n;
      mtvec_q    <= mtvec_n;
      mscratch_q <= mscratch_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
      mtval_q    <= mtval_n;
      mip_q      <= mip_n;
      inhibit_q  <= inhibit_n;
    end
  end

  assign cnt_wr_cycle_o   = wr.wr_v & (wr.wr_addr == csr_mcycle);
  assign cnt_wr_instret_o = wr.wr_v & (wr.wr_addr == csr_minstret);
  assign cnt_wdata_o      = wr.wr_data;
  assign inhibit_o        = inhibit_q;

  assign upd.mstatus_mie  = mstatus_q[MSTATUS_MIE];
  assign upd.mstatus_mpie = mstatus_q[MSTATUS_MPIE];
  assign upd.mstatus_mpp  = priv_e'(mstatus_q[MSTATUS_MPP +: 2]);
  assign upd.mtvec_base   = {mtvec_q[XLEN-1:2], 2'b00};
  assign upd.mepc         = mepc_q;
  assign upd.irq_en_pend  = mie_q[CAUSE_W-1:0] & mip_q[CAUSE_W-1:0];

endmodule

/* csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           csr_cmd_v_i,
  input  csr_pkg::csr_op_e               csr_op_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  input  logic                           retire_v_i,
  input  csr_pkg::exc_vec_t              retire_exc_i,
  input  logic                           retire_irq_i,
  input  logic                           retire_mret_i,
  input  logic [csr_pkg::XLEN-1:0]       retire_npc_i,
  input  logic [csr_pkg::XLEN-1:0]       retire_vaddr_i,
  input  logic [csr_pkg::XLEN-1:0]       retire_instr_i,
  input  logic                           timer_irq_i,
  input  logic                           software_irq_i,
  input  logic                           external_irq_i,
  output logic [csr_pkg::XLEN-1:0]       csr_data_o,
  output logic                           csr_illegal_o,
  output logic [csr_pkg::XLEN-1:0]       commit_npc_o,
  output logic                           commit_trap_o,
  output logic                           commit_interrupt_o,
  output logic                           irq_pending_o,
  output csr_pkg::priv_e                 priv_o
);
  import csr_pkg::*;

  logic [XLEN-1:0] mcycle;
  logic [XLEN-1:0] minstret;
  logic [XLEN-1:0] cnt_wdata;
  logic            cnt_wr_cycle;
  logic            cnt_wr_instret;
  logic [1:0]      inhibit;

  csr_wr_if   wr_bus ();
  trap_upd_if trap_bus ();

  csr_access access_i
  (
    .cmd_v_i   (csr_cmd_v_i),
    .op_i      (csr_op_i),
    .addr_i    (csr_addr_i),
    .wdata_i   (csr_wdata_i),
    .priv_i    (priv_o),
    .data_o    (csr_data_o),
    .illegal_o (csr_illegal_o),
    .wr        (wr_bus.access)
  );

  csr_regfile regfile_i
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .irq_timer_i      (timer_irq_i),
    .irq_soft_i       (software_irq_i),
    .irq_ext_i        (external_irq_i),
    .mcycle_i         (mcycle),
    .minstret_i       (minstret),
    .cnt_wr_cycle_o   (cnt_wr_cycle),
    .cnt_wr_instret_o (cnt_wr_instret),
    .cnt_wdata_o      (cnt_wdata),
    .inhibit_o        (inhibit),
    .wr               (wr_bus.regfile),
    .upd              (trap_bus.slave)
  );

  trap_ctrl trap_i
  (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .retire_v_i         (retire_v_i),
    .retire_exc_i       (retire_exc_i),
    .retire_irq_i       (retire_irq_i),
    .retire_mret_i      (retire_mret_i),
    .retire_npc_i       (retire_npc_i),
    .retire_vaddr_i     (retire_vaddr_i),
    .retire_instr_i     (retire_instr_i),
    .priv_o             (priv_o),
    .commit_npc_o       (commit_npc_o),
    .commit_trap_o      (commit_trap_o),
    .commit_interrupt_o (commit_interrupt_o),
    .irq_pending_o      (irq_pending_o),
    .upd                (trap_bus.master)
  );

  perf_counters counters_i
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .retire_v_i   (retire_v_i),
    .wr_cycle_i   (cnt_wr_cycle),
    .wr_instret_i (cnt_wr_instret),
    .wdata_i      (cnt_wdata),
    .inhibit_i    (inhibit),
    .mcycle_o     (mcycle),
    .minstret_o   (minstret)
  );

endmodule

/* perf_counters.sv */
`timescale 1ns/1ps

module perf_counters
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     retire_v_i,
  input  logic                     wr_cycle_i,
  input  logic                     wr_instret_i,
  input  logic [csr_pkg::XLEN-1:0] wdata_i,
  input  logic [1:0]               inhibit_i,
  output logic [csr_pkg::XLEN-1:0] mcycle_o,
  output logic [csr_pkg::XLEN-1:0] minstret_o
);
  import csr_pkg::*;

  logic [XLEN-1:0] mcycle_q;
  logic [XLEN-1:0] minstret_q;

  // Software write beats the increment
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end
    else
    begin
      if (wr_cycle_i)
        mcycle_q <= wdata_i;
      else if (!inhibit_i[0])
        mcycle_q <= mcycle_q + XLEN'(1);

      if (wr_instret_i)
        minstret_q <= wdata_i;
      else if (retire_v_i && !inhibit_i[1])
        minstret_q <= minstret_q + XLEN'(1);
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

  a_cycle_frozen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inhibit_i[0] && !wr_cycle_i |=> $stable(mcycle_o));

endmodule

/* tb.f */
csr_pkg.sv
csr_if.sv
csr_access.sv
csr_regfile.sv
trap_ctrl.sv
perf_counters.sv
csr_unit.sv
tb_csr_unit.sv

/* tb_csr_unit.sv */
`timescale 1ns/1ps

module tb_csr_unit;
  import csr_pkg::*;

  // Stimulus cycles over all tests, with room to spare
  localparam int STEP_COUNT  = 150;
  localparam int TIMEOUT_CYC = STEP_COUNT * 20 + 100;
  localparam int IDLE_GAP    = 7;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  csr_cmd_v_i;
  csr_op_e               csr_op_i;
  logic [CSR_ADDR_W-1:0] csr_addr_i;
  logic [XLEN-1:0]       csr_wdata_i;
  logic                  retire_v_i;
  exc_vec_t              retire_exc_i;
  logic                  retire_irq_i;
  logic                  retire_mret_i;
  logic [XLEN-1:0]       retire_npc_i;
  logic [XLEN-1:0]       retire_vaddr_i;
  logic [XLEN-1:0]       retire_instr_i;
  logic                  timer_irq_i;
  logic                  software_irq_i;
  logic                  external_irq_i;
  logic [XLEN-1:0]       csr_data_o;
  logic                  csr_illegal_o;
  logic [XLEN-1:0]       commit_npc_o;
  logic                  commit_trap_o;
  logic                  commit_interrupt_o;
  logic                  irq_pending_o;
  priv_e                 priv_o;

  // Reference state
  logic [XLEN-1:0] m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval, m_mip;
  logic [XLEN-1:0] m_mcycle;
  logic [XLEN-1:0] m_minstret;
  logic [XLEN-1:0] m_pc;
  logic [1:0]      m_inhibit;
  priv_e           m_priv;

  logic [XLEN-1:0] exp_data;
  logic [XLEN-1:0] exp_npc;
  logic            exp_illegal;
  logic            exp_trap;
  logic            exp_irq;
  logic            exp_pending;
  priv_e           exp_priv;
  int              check_count;

  csr_unit csr_unit_i (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] act,
                            input logic [XLEN-1:0] exp);
    check_count++;
    if (act !== exp)
      fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    check_count++;
    if (act !== exp)
      fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic check_priv(input string name, input priv_e act, input priv_e exp);
    check_count++;
    if (act !== exp)
      fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  function automatic logic [ECODE_W-1:0] first_set(input logic [15:0] vec);
    int i;
    i = 0;
    while (i < 15 && !vec[i])
      i++;
    return ECODE_W'(i);
  endfunction

  function automatic logic [XLEN-1:0] pack_mstatus(input logic [1:0] mpp, input logic mpie,
                                                   input logic mie);
    return {51'd0, mpp, 3'd0, mpie, 3'd0, mie, 3'd0};
  endfunction

  function automatic logic addr_known(input logic [CSR_ADDR_W-1:0] a);
    case (a)
      csr_mstatus, csr_misa, csr_mie, csr_mtvec, csr_mcountinhibit, csr_mscratch, csr_mepc,
      csr_mcause, csr_mtval, csr_mip, csr_mcycle, csr_minstret, csr_cycle, csr_instret,
      csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] ref_read(input logic [CSR_ADDR_W-1:0] a);
    case (a)
      csr_mcycle, csr_cycle:     return m_mcycle;
      csr_minstret, csr_instret: return m_minstret;
      csr_marchid:               return MARCHID_VAL;
      csr_mimpid:                return MIMPID_VAL;
      csr_misa:                  return MISA_VAL;
      csr_mstatus:               return m_mstatus;
      csr_mie:                   return m_mie;
      csr_mtvec:                 return m_mtvec;
      csr_mscratch:              return m_mscratch;
      csr_mepc:                  return m_mepc;
      csr_mcause:                return m_mcause;
      csr_mtval:                 return m_mtval;
      csr_mip:                   return m_mip;
      csr_mcountinhibit:         return {61'd0, m_inhibit[1], 1'b0, m_inhibit[0]};
      default:                   return '0;
    endcase
  endfunction

  function automatic void model_reset();
    m_mstatus  = '0;
    m_mie      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mip      = '0;
    m_mcycle   = '0;
    m_minstret = '0;
    m_inhibit  = '0;
    m_pc       = BOOT_PC;
    m_priv     = priv_m;
  endfunction

  // Expected outputs for this cycle, then the state after the next edge
  function automatic void model_cycle();
    logic [XLEN-1:0]    src;
    logic [XLEN-1:0]    nv;
    logic [XLEN-1:0]    old_mstatus;
    logic [15:0]        en_pend;
    logic               wr;
    logic               gie;
    logic               mret;
    logic [ECODE_W-1:0] code;
    exp_data    = ref_read(csr_addr_i);
    exp_illegal = csr_cmd_v_i && (2'(m_priv) < csr_addr_i[9:8] || !addr_known(csr_addr_i));
    wr          = csr_cmd_v_i && !exp_illegal && csr_op_i != csrr;
    if (csr_op_i inside {csrrwi, csrrsi, csrrci})
      src = {59'd0, csr_wdata_i[4:0]};
    else
      src = csr_wdata_i;
    case (csr_op_i)
      csrrw, csrrwi: nv = src;
      csrrs, csrrsi: nv = exp_data | src;
      csrrc, csrrci: nv = exp_data & ~src;
      default:       nv = exp_data;
    endcase

    gie         = (m_priv == priv_u) || m_mstatus[3];
    en_pend     = m_mie[15:0] & m_mip[15:0];
    exp_pending = gie && (en_pend != '0);
    exp_irq     = retire_irq_i && exp_pending;
    exp_trap    = exp_irq || (retire_exc_i != '0);
    mret        = retire_mret_i && !exp_trap;
    code        = exp_irq ? first_set(en_pend) : first_set(retire_exc_i);
    exp_priv    = m_priv;
    if (exp_trap)
      exp_npc = {m_mtvec[XLEN-1:2], 2'b00};
    else if (mret)
      exp_npc = m_mepc;
    else if (retire_v_i)
      exp_npc = retire_npc_i;
    else
      exp_npc = m_pc;

    // Counters see the inhibit bits from before this cycle's write
    if (wr && csr_addr_i == csr_mcycle)
      m_mcycle = nv;
    else if (!m_inhibit[0])
      m_mcycle++;
    if (wr && csr_addr_i == csr_minstret)
      m_minstret = nv;
    else if (retire_v_i && !m_inhibit[1])
      m_minstret++;

    old_mstatus = m_mstatus;
    if (wr)
    begin
      case (csr_addr_i)
        csr_mstatus:
          m_mstatus = pack_mstatus((nv[12:11] == 2'b11) ? 2'b11 : 2'b00, nv[7], nv[3]);
        csr_mie:           m_mie      = nv;
        csr_mtvec:         m_mtvec    = nv;
        csr_mscratch:      m_mscratch = nv;
        csr_mepc:          m_mepc     = nv;
        csr_mcause:        m_mcause   = nv;
        csr_mtval:         m_mtval    = nv;
        csr_mcountinhibit: m_inhibit  = {nv[2], nv[0]};
        default:           m_mip      = m_mip;
      endcase
    end

    if (exp_trap)
    begin
      m_mstatus = pack_mstatus(2'(m_priv), old_mstatus[3], 1'b0);
      m_mepc    = m_pc;
      m_mcause  = {exp_irq, 59'd0, code};
      if (exp_irq)
        m_mtval = '0;
      else if (code == EXC_ILLEGAL_INSTR)
        m_mtval = retire_instr_i;
      else
        m_mtval = retire_vaddr_i;
      m_priv = priv_m;
    end
    else if (mret)
    begin
      m_mstatus = pack_mstatus(2'b00, 1'b1, old_mstatus[7]);
      m_priv    = priv_e'(old_mstatus[12:11]);
    end
    m_pc  = exp_npc;
    m_mip = {52'd0, external_irq_i, 3'd0, timer_irq_i, 3'd0, software_irq_i, 3'd0};
  endfunction

  always @(negedge clk_i)
  begin
    if (!rst_n_i)
      model_reset();
    else
    begin
      model_cycle();
      if (csr_cmd_v_i)
        check_data("csr_data_o", csr_data_o, exp_data);
      check_flag("csr_illegal_o", csr_illegal_o, exp_illegal);
      check_data("commit_npc_o", commit_npc_o, exp_npc);
      check_flag("commit_trap_o", commit_trap_o, exp_trap);
      check_flag("commit_interrupt_o", commit_interrupt_o, exp_irq);
      check_flag("irq_pending_o", irq_pending_o, exp_pending);
      check_priv("priv_o", priv_o, exp_priv);
    end
  end

  task automatic clear_inputs();
    csr_cmd_v_i    <= 1'b0;
    csr_op_i       <= csrr;
    csr_addr_i     <= csr_mscratch;
    csr_wdata_i    <= '0;
    retire_v_i     <= 1'b0;
    retire_exc_i   <= '0;
    retire_irq_i   <= 1'b0;
    retire_mret_i  <= 1'b0;
    retire_npc_i   <= '0;
    retire_vaddr_i <= '0;
    retire_instr_i <= '0;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      clear_inputs();
    end
  endtask

  task automatic csr_cmd(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
                         input logic [XLEN-1:0] data);
    @(posedge clk_i);
    clear_inputs();
    csr_cmd_v_i <= 1'b1;
    csr_op_i    <= op;
    csr_addr_i  <= addr;
    csr_wdata_i <= data;
  endtask

  task automatic sample_read(input logic [CSR_ADDR_W-1:0] addr, output logic [XLEN-1:0] val);
    csr_cmd(csrr, addr, '0);
    @(negedge clk_i);
    val = csr_data_o;
  endtask

  task automatic retire(input exc_vec_t exc, input logic irq, input logic mret,
                        input logic [XLEN-1:0] npc);
    @(posedge clk_i);
    clear_inputs();
    retire_v_i     <= 1'b1;
    retire_exc_i   <= exc;
    retire_irq_i   <= irq;
    retire_mret_i  <= mret;
    retire_npc_i   <= npc;
    retire_vaddr_i <= {$urandom, $urandom};
    retire_instr_i <= {32'd0, $urandom};
  endtask

  task automatic set_irq_lines(input logic sw, input logic tm, input logic ex);
    @(posedge clk_i);
    clear_inputs();
    software_irq_i <= sw;
    timer_irq_i    <= tm;
    external_irq_i <= ex;
  endtask

  function automatic csr_op_e pick_op();
    case ($urandom_range(0, 5))
      0:       return csrrw;
      1:       return csrrs;
      2:       return csrrc;
      3:       return csrrwi;
      4:       return csrrsi;
      default: return csrrci;
    endcase
  endfunction

  initial
  begin
    logic [XLEN-1:0] t0;
    logic [XLEN-1:0] t1;
    exc_vec_t        exc;
    void'($urandom(48));
    check_count = 0;
    rst_n_i        <= 1'b0;
    timer_irq_i    <= 1'b0;
    software_irq_i <= 1'b0;
    external_irq_i <= 1'b0;
    clear_inputs();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Read-modify-write on mscratch and mtvec
    repeat (16)
    begin
      csr_cmd(pick_op(), ($urandom_range(0, 1) == 0) ? csr_mscratch : csr_mtvec,
              {$urandom, $urandom});
      csr_cmd(csrr, csr_mscratch, '0);
    end

    // Information registers and unknown addresses
    csr_cmd(csrr, csr_mimpid, '0);
    csr_cmd(csrr, csr_misa, '0);
    csr_cmd(csrrw, csr_marchid, {$urandom, $urandom});
    csr_cmd(csrrs, csr_misa, '1);
    csr_cmd(csrr, csr_misa, '0);
    sample_read(csr_marchid, t0);
    check_data("marchid", t0, MARCHID_VAL);
    csr_cmd(csrrw, 12'h7c0, '1);
    @(negedge clk_i);
    check_flag("csr_illegal_o", csr_illegal_o, 1'b1);
    csr_cmd(csrr, 12'h123, '0);

    // Synchronous exceptions in M mode
    csr_cmd(csrrw, csr_mtvec, {$urandom, $urandom});
    repeat (8)
    begin
      retire('0, 1'b0, 1'b0, {$urandom, $urandom});
      exc = 16'($urandom) & 16'h095d;
      if (exc == '0)
        exc = 16'h0004;
      retire(exc, 1'b0, 1'b0, {$urandom, $urandom});
      csr_cmd(csrr, csr_mcause, '0);
      csr_cmd(csrr, csr_mepc, '0);
      csr_cmd(csrr, csr_mtval, '0);
    end

    // Interrupts, lowest enabled cause first
    csr_cmd(csrrs, csr_mie, 64'h888);
    csr_cmd(csrrsi, csr_mstatus, 64'd8);
    set_irq_lines(1'b0, 1'b1, 1'b1);
    retire('0, 1'b1, 1'b0, {$urandom, $urandom});
    csr_cmd(csrr, csr_mcause, '0);
    csr_cmd(csrrsi, csr_mstatus, 64'd8);
    set_irq_lines(1'b1, 1'b1, 1'b1);
    retire('0, 1'b1, 1'b0, {$urandom, $urandom});
    csr_cmd(csrr, csr_mcause, '0);
    retire('0, 1'b1, 1'b0, {$urandom, $urandom});
    @(negedge clk_i);
    check_flag("irq_pending_o", irq_pending_o, 1'b0);
    check_flag("commit_interrupt_o", commit_interrupt_o, 1'b0);

    // mret into U, then ecall back to M
    set_irq_lines(1'b0, 1'b0, 1'b0);
    csr_cmd(csrrc, csr_mstatus, 64'h1800);
    csr_cmd(csrrw, csr_mepc, {32'd0, $urandom});
    retire('0, 1'b0, 1'b1, '0);
    csr_cmd(csrr, csr_mscratch, '0);
    @(negedge clk_i);
    check_priv("priv_o", priv_o, priv_u);
    check_flag("csr_illegal_o", csr_illegal_o, 1'b1);
    csr_cmd(csrr, csr_cycle, '0);
    retire(exc_vec_t'(16'h0100), 1'b0, 1'b0, {$urandom, $urandom});
    idle(1);
    @(negedge clk_i);
    check_priv("priv_o", priv_o, priv_m);

    // Counters with and without inhibit
    sample_read(csr_mcycle, t0);
    idle(IDLE_GAP - 1);
    sample_read(csr_mcycle, t1);
    check_data("mcycle delta", t1 - t0, 64'(IDLE_GAP));
    repeat (5) retire('0, 1'b0, 1'b0, {$urandom, $urandom});
    csr_cmd(csrr, csr_minstret, '0);
    csr_cmd(csrrwi, csr_mcountinhibit, 64'd5);
    sample_read(csr_mcycle, t0);
    idle(4);
    repeat (3) retire('0, 1'b0, 1'b0, {$urandom, $urandom});
    sample_read(csr_mcycle, t1);
    check_data("mcycle delta", t1 - t0, 64'd0);
    csr_cmd(csrr, csr_minstret, '0);
    csr_cmd(csrrwi, csr_mcountinhibit, 64'd0);
    csr_cmd(csrrw, csr_mcycle, {$urandom, $urandom});
    csr_cmd(csrrw, csr_minstret, {$urandom, $urandom});
    csr_cmd(csrr, csr_cycle, '0);
    csr_cmd(csrr, csr_instret, '0);
    idle(2);

    if (check_count == 0)
      fail_run("no output was compared during the run");
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

  initial
  begin
    #(TIMEOUT_CYC * 10);
    fail_run("watchdog timeout: the stimulus did not finish in time");
  end

endmodule

/* trap_ctrl.sv */
`timescale 1ns/1ps

module trap_ctrl
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     retire_v_i,
  input  csr_pkg::exc_vec_t        retire_exc_i,
  input  logic                     retire_irq_i,
  input  logic                     retire_mret_i,
  input  logic [csr_pkg::XLEN-1:0] retire_npc_i,
  input  logic [csr_pkg::XLEN-1:0] retire_vaddr_i,
  input  logic [csr_pkg::XLEN-1:0] retire_instr_i,
  output csr_pkg::priv_e           priv_o,
  output logic [csr_pkg::XLEN-1:0] commit_npc_o,
  output logic                     commit_trap_o,
  output logic                     commit_interrupt_o,
  output logic                     irq_pending_o,
  trap_upd_if.master               upd
);
  import csr_pkg::*;

  priv_e              priv_q;
  priv_e              priv_n;
  logic [XLEN-1:0]    pc_q;
  logic [XLEN-1:0]    pc_n;
  logic               gie;
  logic               irq_take;
  logic               exc_take;
  logic [ECODE_W-1:0] irq_code;
  logic [ECODE_W-1:0] exc_code;

  // U mode can always be interrupted by M
  assign gie           = (priv_q == priv_u) | upd.mstatus_mie;
  assign irq_pending_o = gie & (|upd.irq_en_pend);

  assign irq_take = retire_irq_i & irq_pending_o;
  assign exc_take = ~irq_take & (|retire_exc_i);
  assign irq_code = lowest_set(upd.irq_en_pend);
  assign exc_code = lowest_set(retire_exc_i);

  assign upd.trap_v    = irq_take | exc_take;
  assign upd.mret_v    = retire_mret_i & ~upd.trap_v;
  assign upd.epc       = pc_q;
  assign upd.cause     = irq_take ? {1'b1, irq_code} : {1'b0, exc_code};
  assign upd.prev_priv = priv_q;

  always_comb
  begin
    if (irq_take)
      upd.tval = '0;
    else if (exc_code == EXC_ILLEGAL_INSTR)
      upd.tval = retire_instr_i;
    else
      upd.tval = retire_vaddr_i;
  end

  always_comb
  begin
    pc_n   = pc_q;
    priv_n = priv_q;
    if (upd.trap_v)
    begin
      pc_n   = upd.mtvec_base;
      priv_n = priv_m;
    end
    else if (upd.mret_v)
    begin
      pc_n   = upd.mepc;
      priv_n = upd.mstatus_mpp;
    end
    else if (retire_v_i)
      pc_n = retire_npc_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pc_q   <= BOOT_PC;
      priv_q <= priv_m;
    end
    else
    begin
      pc_q   <= pc_n;
      priv_q <= priv_n;
    end
  end

  assign priv_o             = priv_q;
  assign commit_npc_o       = pc_n;
  assign commit_trap_o      = upd.trap_v;
  assign commit_interrupt_o = irq_take;

  // Regfile saves the trapping PC in mepc
  a_trap_mepc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd.trap_v |=> upd.mepc == $past(upd.epc));

  // Regfile restores MIE from MPIE one edge after mret
  a_mret_mie: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd.mret_v |=> upd.mstatus_mie == $past(upd.mstatus_mpie));

endmodule
